// File: include/mpu_cfg.svh
`ifndef MPU_CFG_SVH
`define MPU_CFG_SVH

`define PORT_DIR1     16'h0000    // port 1 direction
`define PORT_DIR2     16'h0001
`define PORT_DAT1     16'h0002    // port 1 data
`define PORT_DAT2     16'h0003
`define PORT_DIR3     16'h0004
`define PORT_DIR4     16'h0005
`define PORT_DAT3     16'h0006
`define PORT_DAT4     16'h0007

`define CTR_HI        16'h0009    // free running counter msb
`define CTR_LO        16'h000A

`define SCI_STAT      16'h0011    // serial status
`define SCI_RXD       16'h0012    // receive byte
`define SCI_TXD       16'h0013    // transmit byte

`define IRQ_VEC_HI    16'hFFF8    // irq vector fetch
`define IRQ_VEC_LO    16'hFFF9

`define SCI_VECTOR    16'hFC7C    // serial handler
`define SCI_ENTRY     16'hFC7C
`define TMR_VECTOR    16'hFFE0    // timer overflow handler
`define TMR_ENTRY     16'hFFE3    // first opcode past the vector stub

`define CTR_PRESCALE  4           // clocks per counter tick
`define BURST_STEPS   64          // address changes per burst
`define STAT_TX_EMPTY 7
`define STAT_RX_FULL  6

`endif

// File: hw/mpu_pkg.sv
package mpu_pkg;

	typedef logic [15:0] addr_t;	// cpu address
	typedef logic [7:0] byte_t;	// cpu data

	// one peripheral's answer to a read
	typedef struct packed {
		logic hit;	// address belongs to this block
		byte_t data;	// zero when no hit
	} rd_resp_t;

	// run / step controller
	typedef enum logic [3:0] {
		IDLE       = 4'd0,	// cpu held
		RUN        = 4'd1,	// free running
		STEP_ARM   = 4'd2,	// record address, release
		STEP_WAIT  = 4'd3,	// wait for address change
		STEP_REL   = 4'd4,	// wait for button up
		BURST_ARM  = 4'd5,
		BURST_WAIT = 4'd6,
		BURST_NEXT = 4'd7,	// count or finish
		BRK_HOLD   = 4'd8	// stopped on breakpoint
	} dbg_state_t;

endpackage

// File: hw/cpu_bus_if.sv
`timescale 1ns/100ps

interface cpu_bus_if (
	input logic SYS_CLK,
	input logic KEY	// async reset, low active
);
	import mpu_pkg::*;

	addr_t addr;	// cpu address
	byte_t wdata;	// cpu write data
	logic wr;	// qualified write strobe
	logic rd;	// qualified read strobe

	modport host (output addr, output wdata, output wr, output rd);
	modport periph (input SYS_CLK, input KEY, input addr, input wdata, input wr, input rd);

endinterface

// File: hw/periph_bus.sv
`timescale 1ns/100ps

module periph_bus (
	cpu_bus_if.host bus,
	input mpu_pkg::addr_t addr,
	input logic rw,	// high = read
	input mpu_pkg::byte_t wdata,
	input logic stall,
	input mpu_pkg::byte_t mem_rdata,	// ram / rom data from outside
	input mpu_pkg::rd_resp_t port_rd,
	input mpu_pkg::rd_resp_t ctr_rd,
	input mpu_pkg::rd_resp_t sci_rd,
	input mpu_pkg::rd_resp_t vec_rd,
	output mpu_pkg::byte_t rdata
);
	import mpu_pkg::*;

	logic any_hit;	// some peripheral owns the address
	byte_t hit_data;	// merged peripheral byte

	// a stalled cpu does not access anything
	assign bus.addr = addr;
	assign bus.wdata = wdata;
	assign bus.wr = !rw && !stall;
	assign bus.rd = rw && !stall;

	always_comb begin
		any_hit = port_rd.hit | ctr_rd.hit | sci_rd.hit | vec_rd.hit;
		hit_data = '0;
		if (port_rd.hit)
			hit_data = hit_data | port_rd.data;
		if (ctr_rd.hit)
			hit_data = hit_data | ctr_rd.data;
		if (sci_rd.hit)
			hit_data = hit_data | sci_rd.data;
		if (vec_rd.hit)
			hit_data = hit_data | vec_rd.data;	// overrides rom vector
	end

	// only one block decodes any given address
	assign rdata = any_hit ? hit_data : mem_rdata;	// fall back to memory

endmodule

// File: hw/port_regs.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module port_regs (
	cpu_bus_if.periph bus,
	output mpu_pkg::rd_resp_t rd_resp,
	output mpu_pkg::byte_t [3:0] port_out	// masked pins, ports 1..4
);
	import mpu_pkg::*;

	localparam addr_t DIR_ADDR [4] = '{`PORT_DIR1, `PORT_DIR2, `PORT_DIR3, `PORT_DIR4};
	localparam addr_t DAT_ADDR [4] = '{`PORT_DAT1, `PORT_DAT2, `PORT_DAT3, `PORT_DAT4};

	byte_t [3:0] dir_q;	// 1 = output
	byte_t [3:0] dat_q;

	always_ff @(posedge bus.SYS_CLK or negedge bus.KEY) begin
		if (!bus.KEY) begin
			dir_q <= '0;	// all inputs
			dat_q <= '0;
		end else if (bus.wr) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.addr == DIR_ADDR[i])
					dir_q[i] <= bus.wdata;
				if (bus.addr == DAT_ADDR[i])
					dat_q[i] <= bus.wdata;
			end
		end
	end

	always_comb begin
		rd_resp = '0;
		for (int i = 0; i < 4; i++) begin
			if (bus.addr == DIR_ADDR[i]) begin
				rd_resp.hit = 1'b1;
				rd_resp.data = dir_q[i];
			end
			if (bus.addr == DAT_ADDR[i]) begin
				rd_resp.hit = 1'b1;
				rd_resp.data = dat_q[i];	// register, not pins
			end
		end
	end

	assign port_out = dat_q & dir_q;	// input bits read as 0 on the pins

endmodule

// File: hw/free_counter.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module free_counter (
	cpu_bus_if.periph bus,
	output mpu_pkg::rd_resp_t rd_resp,
	output logic wrap	// one clock after ffff -> 0000
);
	localparam int PRE_W = $clog2(`CTR_PRESCALE);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`CTR_PRESCALE - 1);

	logic [PRE_W-1:0] pre_q;	// prescaler
	logic [15:0] ctr_q;
	logic tick;	// counter advances this edge
	logic wr_hi;
	logic wr_lo;

	assign tick = (pre_q == PRE_LAST);
	assign wr_hi = bus.wr && (bus.addr == `CTR_HI);
	assign wr_lo = bus.wr && (bus.addr == `CTR_LO);

	always_ff @(posedge bus.SYS_CLK or negedge bus.KEY) begin
		if (!bus.KEY) begin
			pre_q <= '0;
			ctr_q <= '0;
			wrap <= 1'b0;
		end else begin
			pre_q <= tick ? '0 : pre_q + 1'b1;
			wrap <= tick && !wr_hi && !wr_lo && (ctr_q == 16'hFFFF);
			if (wr_hi)
				ctr_q[15:8] <= bus.wdata;	// cpu write beats the tick
			else if (wr_lo)
				ctr_q[7:0] <= bus.wdata;
			else if (tick)
				ctr_q <= ctr_q + 16'd1;
		end
	end

	always_comb begin
		rd_resp = '0;
		if (bus.addr == `CTR_HI) begin
			rd_resp.hit = 1'b1;
			rd_resp.data = ctr_q[15:8];
		end else if (bus.addr == `CTR_LO) begin
			rd_resp.hit = 1'b1;
			rd_resp.data = ctr_q[7:0];
		end
	end

endmodule

// File: hw/sci_regs.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module sci_regs (
	cpu_bus_if.periph bus,
	output mpu_pkg::rd_resp_t rd_resp,
	input logic rx_valid,	// byte from midi in
	input mpu_pkg::byte_t rx_data,
	output logic rx_ready,
	output logic tx_valid,	// byte for midi out
	output mpu_pkg::byte_t tx_data,
	input logic tx_ready,
	output logic rx_accept	// to irq latch
);
	import mpu_pkg::*;

	logic rx_full_q;
	byte_t rx_data_q;
	logic rd_rxd;	// cpu takes the received byte
	logic wr_txd;
	logic tx_load;	// write lands in an empty slot

	assign rx_ready = !rx_full_q;	// one byte deep
	assign rx_accept = rx_valid && rx_ready;
	assign rd_rxd = bus.rd && (bus.addr == `SCI_RXD);
	assign wr_txd = bus.wr && (bus.addr == `SCI_TXD);
	assign tx_load = wr_txd && !tx_valid;	// write to a full slot is lost

	always_ff @(posedge bus.SYS_CLK or negedge bus.KEY) begin
		if (!bus.KEY) begin
			rx_full_q <= 1'b0;
			tx_valid <= 1'b0;
		end else begin
			if (rx_accept)
				rx_full_q <= 1'b1;
			else if (rd_rxd)
				rx_full_q <= 1'b0;
			if (tx_valid && tx_ready)
				tx_valid <= 1'b0;	// taken by the transmitter
			else if (tx_load)
				tx_valid <= 1'b1;
		end
	end

	always_ff @(posedge bus.SYS_CLK) begin
		if (rx_accept)
			rx_data_q <= rx_data;
		if (tx_load)
			tx_data <= bus.wdata;	// held until tx_ready
	end

	always_comb begin
		rd_resp = '0;
		if (bus.addr == `SCI_STAT) begin
			rd_resp.hit = 1'b1;
			rd_resp.data[`STAT_TX_EMPTY] = !tx_valid;
			rd_resp.data[`STAT_RX_FULL] = rx_full_q;
		end else if (bus.addr == `SCI_RXD) begin
			rd_resp.hit = 1'b1;
			rd_resp.data = rx_data_q;
		end
	end

endmodule

// File: hw/irq_ctrl.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module irq_ctrl (
	cpu_bus_if.periph bus,
	input logic rx_accept,	// serial byte arrived
	input logic wrap,	// counter overflow
	output mpu_pkg::rd_resp_t vec_rd,
	output logic irq
);
	import mpu_pkg::*;

	localparam addr_t SCI_VEC = `SCI_VECTOR;
	localparam addr_t TMR_VEC = `TMR_VECTOR;

	logic sci_pend_q;
	logic tmr_pend_q;
	addr_t vec;	// handler for the winning source

	// a source is serviced once the cpu fetches its handler entry
	always_ff @(posedge bus.SYS_CLK or negedge bus.KEY) begin
		if (!bus.KEY) begin
			sci_pend_q <= 1'b0;
			tmr_pend_q <= 1'b0;
		end else begin
			if (bus.addr == `SCI_ENTRY)
				sci_pend_q <= 1'b0;	// clear wins
			else if (rx_accept)
				sci_pend_q <= 1'b1;
			if (bus.addr == `TMR_ENTRY)
				tmr_pend_q <= 1'b0;
			else if (wrap)
				tmr_pend_q <= 1'b1;
		end
	end

	assign irq = sci_pend_q | tmr_pend_q;
	assign vec = sci_pend_q ? SCI_VEC : TMR_VEC;	// sci first

	always_comb begin
		vec_rd = '0;	// no source, rom vector goes through
		if (irq && (bus.addr == `IRQ_VEC_HI)) begin
			vec_rd.hit = 1'b1;
			vec_rd.data = vec[15:8];
		end else if (irq && (bus.addr == `IRQ_VEC_LO)) begin
			vec_rd.hit = 1'b1;
			vec_rd.data = vec[7:0];
		end
	end

endmodule

// File: hw/step_ctrl.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module step_ctrl (
	cpu_bus_if.periph bus,
	input logic run_sw,
	input logic brk_sw,	// breakpoint enable
	input logic brk_match,
	input logic step_btn,
	input logic burst_btn,
	output logic stall	// holds the cpu
);
	import mpu_pkg::*;

	localparam int CNT_W = $clog2(`BURST_STEPS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`BURST_STEPS - 1);

	dbg_state_t state_q;
	addr_t rec_addr_q;	// address when the step began
	logic [CNT_W-1:0] cnt_q;	// steps done in this burst

	always_ff @(posedge bus.SYS_CLK or negedge bus.KEY) begin
		if (!bus.KEY) begin
			state_q <= IDLE;
			stall <= 1'b1;	// come up halted
			rec_addr_q <= '0;
			cnt_q <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					stall <= 1'b1;
					if (run_sw) begin
						stall <= 1'b0;
						state_q <= RUN;
					end else if (step_btn) begin
						state_q <= STEP_ARM;
					end else if (burst_btn) begin
						cnt_q <= '0;
						state_q <= BURST_ARM;
					end
				end
				RUN: begin
					if (!run_sw) begin
						stall <= 1'b1;
						state_q <= IDLE;
					end else if (brk_sw && brk_match) begin
						stall <= 1'b1;	// stop on breakpoint
						state_q <= BRK_HOLD;
					end
				end
				BRK_HOLD: if (!run_sw) state_q <= IDLE;	// stay until run drops
				STEP_ARM, BURST_ARM: begin
					rec_addr_q <= bus.addr;
					stall <= 1'b0;
					state_q <= (state_q == STEP_ARM) ? STEP_WAIT : BURST_WAIT;
				end
				STEP_WAIT, BURST_WAIT: begin
					if (bus.addr != rec_addr_q) begin	// cpu moved on
						stall <= 1'b1;
						state_q <= (state_q == STEP_WAIT) ? STEP_REL : BURST_NEXT;
					end
				end
				STEP_REL: if (!step_btn) state_q <= IDLE;
				BURST_NEXT: begin
					if (cnt_q != CNT_LAST) begin
						cnt_q <= cnt_q + 1'b1;
						state_q <= BURST_ARM;
					end else if (!burst_btn && !run_sw) begin
						state_q <= IDLE;
					end
				end
				default: begin
					stall <= 1'b1;
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

// File: hw/mpu_periph_top.sv
`timescale 1ns/100ps

module mpu_periph_top (
	input logic SYS_CLK,
	input logic KEY,	// async reset, low active
	input mpu_pkg::addr_t addr,	// cpu bus
	input logic rw,
	input mpu_pkg::byte_t wdata,
	input mpu_pkg::byte_t mem_rdata,	// external memory read data
	input logic rx_valid,
	input mpu_pkg::byte_t rx_data,
	input logic tx_ready,
	input logic run_sw,	// debug controls
	input logic brk_sw,
	input logic brk_match,
	input logic step_btn,
	input logic burst_btn,
	output mpu_pkg::byte_t rdata,
	output logic irq,
	output logic stall,
	output logic rx_ready,
	output logic tx_valid,
	output mpu_pkg::byte_t tx_data,
	output mpu_pkg::byte_t [3:0] port_out
);
	import mpu_pkg::*;

	rd_resp_t port_rd;
	rd_resp_t ctr_rd;
	rd_resp_t sci_rd;
	rd_resp_t vec_rd;	// irq vector override
	logic wrap;
	logic rx_accept;

	cpu_bus_if u_bus (.SYS_CLK(SYS_CLK), .KEY(KEY));

	periph_bus u_periph_bus (
		.bus(u_bus), .addr(addr), .rw(rw), .wdata(wdata), .stall(stall),
		.mem_rdata(mem_rdata), .port_rd(port_rd), .ctr_rd(ctr_rd), .sci_rd(sci_rd),
		.vec_rd(vec_rd), .rdata(rdata)
	);

	port_regs u_port_regs (.bus(u_bus), .rd_resp(port_rd), .port_out(port_out));

	free_counter u_free_counter (.bus(u_bus), .rd_resp(ctr_rd), .wrap(wrap));

	sci_regs u_sci_regs (
		.bus(u_bus), .rd_resp(sci_rd), .rx_valid(rx_valid), .rx_data(rx_data),
		.rx_ready(rx_ready), .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
		.rx_accept(rx_accept)
	);

	irq_ctrl u_irq_ctrl (
		.bus(u_bus), .rx_accept(rx_accept), .wrap(wrap), .vec_rd(vec_rd), .irq(irq)
	);

	step_ctrl u_step_ctrl (
		.bus(u_bus), .run_sw(run_sw), .brk_sw(brk_sw), .brk_match(brk_match),
		.step_btn(step_btn), .burst_btn(burst_btn), .stall(stall)
	);

endmodule

// File: bench/tb_mpu_periph.sv
`timescale 1ns/100ps
`include "mpu_cfg.svh"

module tb_mpu_periph;
	import mpu_pkg::*;

	localparam addr_t IDLE_ADDR = 16'h4000;	// outside the peripheral page
	localparam int CTR_K = 40;	// counter ticks between two reads
	localparam int TEST_CYCLES = 20 + 16 * 8 + `CTR_PRESCALE * CTR_K + 40 + 40 + 40
		+ `BURST_STEPS * 6 + 60;
	localparam int MAX_CYCLES = 2 * TEST_CYCLES;

	logic SYS_CLK, KEY;
	addr_t addr;
	logic rw;
	byte_t wdata, mem_rdata, rx_data, rdata, tx_data;
	logic rx_valid, tx_ready, run_sw, brk_sw, brk_match, step_btn, burst_btn;
	logic irq, stall, rx_ready, tx_valid;
	byte_t [3:0] port_out;

	int seed = 32'h91a6_bc73;
	int cycles = 0;
	int err_cnt = 0;
	string test_name = "reset";
	logic chk_en = 1'b0;
	logic cpu_en = 1'b0;	// cpu model moves addr
	logic moved_last = 1'b0;
	int step_count = 0;	// address changes with stall low

	// shadow of the peripheral state
	byte_t [3:0] m_dir, m_dat;
	logic [1:0] m_pre;
	logic [15:0] m_ctr;
	logic m_wrap, m_tmr_pend, m_sci_pend;
	logic m_rx_full, m_tx_v;
	byte_t m_rx_byte, m_tx_d;
	logic m_stall;
	logic [1:0] m_mode;	// 0 idle, 1 run, 2 breakpoint

	mpu_periph_top u_dut (
		.SYS_CLK(SYS_CLK), .KEY(KEY), .addr(addr), .rw(rw), .wdata(wdata),
		.mem_rdata(mem_rdata), .rx_valid(rx_valid), .rx_data(rx_data), .tx_ready(tx_ready),
		.run_sw(run_sw), .brk_sw(brk_sw), .brk_match(brk_match), .step_btn(step_btn),
		.burst_btn(burst_btn), .rdata(rdata), .irq(irq), .stall(stall),
		.rx_ready(rx_ready), .tx_valid(tx_valid), .tx_data(tx_data), .port_out(port_out)
	);

	initial begin
		SYS_CLK = 1'b0;
		forever #4 SYS_CLK = ~SYS_CLK;	// 125 MHz
	end

	function automatic int dir_slot(addr_t a);
		case (a)
			`PORT_DIR1: return 0;
			`PORT_DIR2: return 1;
			`PORT_DIR3: return 2;
			`PORT_DIR4: return 3;
			default: return -1;
		endcase
	endfunction

	function automatic int dat_slot(addr_t a);
		case (a)
			`PORT_DAT1: return 0;
			`PORT_DAT2: return 1;
			`PORT_DAT3: return 2;
			`PORT_DAT4: return 3;
			default: return -1;
		endcase
	endfunction

	function automatic addr_t dir_addr(int p);
		addr_t t [4] = '{`PORT_DIR1, `PORT_DIR2, `PORT_DIR3, `PORT_DIR4};
		return t[p];
	endfunction

	function automatic addr_t dat_addr(int p);
		addr_t t [4] = '{`PORT_DAT1, `PORT_DAT2, `PORT_DAT3, `PORT_DAT4};
		return t[p];
	endfunction

	// expected cpu read data from the shadow state
	function automatic byte_t ref_read(addr_t a, byte_t mem);
		byte_t r;
		addr_t vec;
		r = mem;	// memory unless a block claims it
		vec = m_sci_pend ? `SCI_VECTOR : `TMR_VECTOR;
		if (dir_slot(a) >= 0)
			r = m_dir[dir_slot(a)];
		else if (dat_slot(a) >= 0)
			r = m_dat[dat_slot(a)];
		else if (a == `CTR_HI)
			r = m_ctr[15:8];
		else if (a == `CTR_LO)
			r = m_ctr[7:0];
		else if (a == `SCI_STAT) begin
			r = '0;
			r[`STAT_TX_EMPTY] = !m_tx_v;
			r[`STAT_RX_FULL] = m_rx_full;
		end else if (a == `SCI_RXD)
			r = m_rx_byte;
		else if ((m_sci_pend || m_tmr_pend) && a == `IRQ_VEC_HI)
			r = vec[15:8];
		else if ((m_sci_pend || m_tmr_pend) && a == `IRQ_VEC_LO)
			r = vec[7:0];
		return r;
	endfunction

	always @(posedge SYS_CLK or negedge KEY) begin : model_update
		logic wr_ok, rd_ok, tick, accept, wr_ctr;
		if (!KEY) begin
			m_dir <= '0;
			m_dat <= '0;
			m_pre <= '0;
			m_ctr <= '0;
			m_wrap <= 1'b0;
			m_tmr_pend <= 1'b0;
			m_sci_pend <= 1'b0;
			m_rx_full <= 1'b0;
			m_tx_v <= 1'b0;
			m_rx_byte <= '0;
			m_tx_d <= '0;
			m_stall <= 1'b1;
			m_mode <= 2'd0;
		end else begin
			wr_ok = !rw && !m_stall;
			rd_ok = rw && !m_stall;
			tick = (m_pre == 2'(`CTR_PRESCALE - 1));
			accept = rx_valid && !m_rx_full;
			wr_ctr = wr_ok && (addr == `CTR_HI || addr == `CTR_LO);
			if (wr_ok && dir_slot(addr) >= 0) m_dir[dir_slot(addr)] <= wdata;
			if (wr_ok && dat_slot(addr) >= 0) m_dat[dat_slot(addr)] <= wdata;
			m_pre <= tick ? 2'd0 : m_pre + 2'd1;
			m_wrap <= tick && !wr_ctr && m_ctr == 16'hFFFF;
			if (wr_ok && addr == `CTR_HI) m_ctr[15:8] <= wdata;
			else if (wr_ok && addr == `CTR_LO) m_ctr[7:0] <= wdata;
			else if (tick) m_ctr <= m_ctr + 16'd1;
			if (addr == `TMR_ENTRY) m_tmr_pend <= 1'b0;	// entry clear first
			else if (m_wrap) m_tmr_pend <= 1'b1;
			if (addr == `SCI_ENTRY) m_sci_pend <= 1'b0;
			else if (accept) m_sci_pend <= 1'b1;
			if (accept) begin
				m_rx_full <= 1'b1;
				m_rx_byte <= rx_data;
			end else if (rd_ok && addr == `SCI_RXD)
				m_rx_full <= 1'b0;
			if (m_tx_v && tx_ready) m_tx_v <= 1'b0;
			else if (wr_ok && addr == `SCI_TXD && !m_tx_v) begin	// full slot drops the write
				m_tx_v <= 1'b1;
				m_tx_d <= wdata;
			end
			case (m_mode)	// run and breakpoint path only
				2'd0: if (run_sw) begin
					m_mode <= 2'd1;
					m_stall <= 1'b0;
				end
				2'd1: if (!run_sw) begin
					m_mode <= 2'd0;
					m_stall <= 1'b1;
				end else if (brk_sw && brk_match) begin
					m_mode <= 2'd2;
					m_stall <= 1'b1;
				end
				default: if (!run_sw) m_mode <= 2'd0;
			endcase
		end
	end

	task automatic report_fail(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		err_cnt++;
		$display("Fail %s %s expected %0h actual %0h", test_name, what, exp, act);
		$display("SOME TESTS FAILED");
		$fatal(1, "check failed");
	endtask

	// compare outputs against the shadow at the falling edge
	always @(negedge SYS_CLK) begin
		if (chk_en) begin
			assert (rdata === ref_read(addr, mem_rdata))
				else report_fail("rdata", 32'(ref_read(addr, mem_rdata)), 32'(rdata));
			assert (irq === (m_sci_pend | m_tmr_pend))
				else report_fail("irq", 32'(m_sci_pend | m_tmr_pend), 32'(irq));
			assert (port_out === (m_dat & m_dir))
				else report_fail("port_out", m_dat & m_dir, port_out);
			assert (tx_valid === m_tx_v) else report_fail("tx_valid", 32'(m_tx_v), 32'(tx_valid));
			assert (!m_tx_v || tx_data === m_tx_d)
				else report_fail("tx_data", 32'(m_tx_d), 32'(tx_data));
			assert (rx_ready === !m_rx_full)
				else report_fail("rx_ready", 32'(!m_rx_full), 32'(rx_ready));
		end
	end

	// cpu model, one address change per released step
	always @(posedge SYS_CLK) begin
		if (cpu_en && !stall && !moved_last) begin
			addr <= addr + 16'd1;
			moved_last <= 1'b1;
			step_count <= step_count + 1;
		end else
			moved_last <= 1'b0;	// instruction takes two clocks
	end

	always @(posedge SYS_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic bus_cycle(input addr_t a, input logic read, input byte_t d);
		int r;
		@(posedge SYS_CLK);
		r = $random(seed);
		addr <= a;
		rw <= read;
		wdata <= d;
		mem_rdata <= r[7:0];	// fresh memory data each access
	endtask

	initial begin
		int r, p, n;
		byte_t dv, tv, v1, v2, b1, b2;
		addr_t vec;
		dbg_state_t st;
		KEY = 1'b0;
		addr = IDLE_ADDR;
		rw = 1'b1;
		wdata = '0;
		mem_rdata = '0;
		rx_valid = 1'b0;
		rx_data = '0;
		tx_ready = 1'b0;
		run_sw = 1'b0;
		brk_sw = 1'b0;
		brk_match = 1'b0;
		step_btn = 1'b0;
		burst_btn = 1'b0;
		repeat (2) @(posedge SYS_CLK);
		KEY <= 1'b1;
		chk_en <= 1'b1;

		@(negedge SYS_CLK);
		assert (stall === 1'b1) else report_fail("stall", 1, 32'(stall));
		assert (irq === 1'b0 && tx_valid === 1'b0 && rx_ready === 1'b1)
			else report_fail("outputs", 32'h1, 32'({irq, tx_valid, rx_ready}));
		assert (port_out === '0) else report_fail("port_out", 0, port_out);
		bus_cycle(16'h4321, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata === mem_rdata) else report_fail("mem read", 32'(mem_rdata), 32'(rdata));
		@(posedge SYS_CLK);
		run_sw <= 1'b1;
		bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (stall === 1'b0) else report_fail("run stall", 0, 32'(stall));

		test_name = "ports";
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			p = int'(r[1:0]);
			dv = r[15:8];
			tv = r[23:16];
			bus_cycle(dir_addr(p), 1'b0, dv);
			bus_cycle(dat_addr(p), 1'b0, tv);
			bus_cycle(dir_addr(p), 1'b1, 8'h00);
			@(negedge SYS_CLK);
			assert (rdata === dv) else report_fail("dir readback", 32'(dv), 32'(rdata));
			bus_cycle(dat_addr(p), 1'b1, 8'h00);
			@(negedge SYS_CLK);
			assert (rdata === tv) else report_fail("data readback", 32'(tv), 32'(rdata));
			assert (port_out[p] === (tv & dv))
				else report_fail("pins", 32'(tv & dv), 32'(port_out[p]));
		end

		test_name = "counter";
		bus_cycle(`CTR_LO, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		v1 = rdata;
		repeat (`CTR_PRESCALE * CTR_K) @(negedge SYS_CLK);
		v2 = rdata;
		assert (byte_t'(v2 - v1) === byte_t'(CTR_K))
			else report_fail("tick delta", CTR_K, 32'(byte_t'(v2 - v1)));
		bus_cycle(`CTR_HI, 1'b0, 8'hFF);
		bus_cycle(`CTR_LO, 1'b0, 8'hFF);
		n = 0;
		do begin
			bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
			@(negedge SYS_CLK);
			n++;
		end while (!irq && n < `CTR_PRESCALE + 2);
		assert (irq === 1'b1) else report_fail("wrap irq", 1, 32'(irq));
		vec = `TMR_VECTOR;
		bus_cycle(`IRQ_VEC_HI, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata === vec[15:8]) else report_fail("vector hi", 32'(vec[15:8]), 32'(rdata));
		bus_cycle(`IRQ_VEC_LO, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata === vec[7:0]) else report_fail("vector lo", 32'(vec[7:0]), 32'(rdata));
		bus_cycle(`TMR_ENTRY, 1'b1, 8'h00);
		bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (irq === 1'b0) else report_fail("entry clear", 0, 32'(irq));

		test_name = "receive";
		r = $random(seed);
		b1 = r[7:0];
		b2 = ~r[7:0];
		@(posedge SYS_CLK);
		rx_valid <= 1'b1;
		rx_data <= b1;
		@(negedge SYS_CLK);
		assert (rx_ready === 1'b1) else report_fail("ready before", 1, 32'(rx_ready));
		@(posedge SYS_CLK);
		rx_data <= b2;	// second byte waits
		@(negedge SYS_CLK);
		assert (rx_ready === 1'b0 && irq === 1'b1)
			else report_fail("accept", 32'h1, {rx_ready, irq});
		vec = `SCI_VECTOR;
		bus_cycle(`IRQ_VEC_HI, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata === vec[15:8]) else report_fail("vector hi", 32'(vec[15:8]), 32'(rdata));
		bus_cycle(`IRQ_VEC_LO, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata === vec[7:0]) else report_fail("vector lo", 32'(vec[7:0]), 32'(rdata));
		bus_cycle(`SCI_STAT, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rdata[`STAT_RX_FULL] === 1'b1) else report_fail("status", 1, 32'(rdata));
		repeat (3) begin
			bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
			@(negedge SYS_CLK);
			assert (rx_ready === 1'b0) else report_fail("held back", 0, 32'(rx_ready));
		end
		bus_cycle(`SCI_RXD, 1'b1, 8'h00);
		rx_valid <= 1'b0;
		@(negedge SYS_CLK);
		assert (rdata === b1) else report_fail("rx byte", 32'(b1), 32'(rdata));
		bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (rx_ready === 1'b1) else report_fail("ready after", 1, 32'(rx_ready));
		bus_cycle(`SCI_ENTRY, 1'b1, 8'h00);
		bus_cycle(IDLE_ADDR, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (irq === 1'b0) else report_fail("entry clear", 0, 32'(irq));

		test_name = "transmit";
		r = $random(seed);
		b1 = r[7:0];
		n = int'(r[10:8]) + 3;	// back-pressure length
		bus_cycle(`SCI_TXD, 1'b0, b1);
		bus_cycle(`SCI_STAT, 1'b1, 8'h00);
		@(negedge SYS_CLK);
		assert (tx_valid === 1'b1 && tx_data === b1)
			else report_fail("tx queued", 32'(b1), 32'(tx_data));
		assert (rdata[`STAT_TX_EMPTY] === 1'b0) else report_fail("status", 0, 32'(rdata));
		bus_cycle(`SCI_TXD, 1'b0, ~b1);	// slot full, lost
		repeat (n) begin
			bus_cycle(`SCI_STAT, 1'b1, 8'h00);
			@(negedge SYS_CLK);
			assert (tx_valid === 1'b1 && tx_data === b1)
				else report_fail("tx held", 32'(b1), 32'(tx_data));
			assert (rdata[`STAT_TX_EMPTY] === 1'b0)
				else report_fail("status held", 0, 32'(rdata));
		end
		@(posedge SYS_CLK);
		tx_ready <= 1'b1;
		@(posedge SYS_CLK);
		tx_ready <= 1'b0;
		@(negedge SYS_CLK);
		assert (tx_valid === 1'b0) else report_fail("tx done", 0, 32'(tx_valid));

		test_name = "debug";
		@(posedge SYS_CLK);
		run_sw <= 1'b0;
		addr <= 16'h2000;
		rw <= 1'b1;
		step_count <= 0;
		repeat (2) @(negedge SYS_CLK);
		@(posedge SYS_CLK);
		cpu_en <= 1'b1;
		step_btn <= 1'b1;
		do @(negedge SYS_CLK); while (stall);
		do @(negedge SYS_CLK); while (!stall);
		@(posedge SYS_CLK);
		step_btn <= 1'b0;
		repeat (4) @(negedge SYS_CLK);
		assert (step_count == 1) else report_fail("step moves", 1, step_count);
		@(posedge SYS_CLK);
		step_count <= 0;
		burst_btn <= 1'b1;
		n = 0;
		while (n < 10) begin	// burst over once stall stays up
			@(negedge SYS_CLK);
			n = stall ? n + 1 : 0;
		end
		assert (step_count == `BURST_STEPS)
			else report_fail("burst moves", `BURST_STEPS, step_count);
		@(posedge SYS_CLK);
		burst_btn <= 1'b0;
		cpu_en <= 1'b0;
		repeat (2) @(negedge SYS_CLK);	// burst ends with both switches low
		assert (stall === 1'b1) else report_fail("burst end", 1, 32'(stall));
		@(posedge SYS_CLK);
		run_sw <= 1'b1;
		repeat (3) @(negedge SYS_CLK);
		assert (stall === 1'b0) else report_fail("run", 0, 32'(stall));
		@(posedge SYS_CLK);
		brk_sw <= 1'b1;
		brk_match <= 1'b1;
		@(posedge SYS_CLK);
		brk_match <= 1'b0;
		repeat (4) begin
			@(negedge SYS_CLK);
			st = u_dut.u_step_ctrl.state_q;
			assert (stall === 1'b1)
				else report_fail($sformatf("break stall in %s", st.name()), 1, 32'(stall));
		end
		@(posedge SYS_CLK);
		run_sw <= 1'b0;
		repeat (3) @(negedge SYS_CLK);
		assert (stall === 1'b1) else report_fail("idle stall", 1, 32'(stall));
		@(posedge SYS_CLK);
		brk_sw <= 1'b0;
		run_sw <= 1'b1;
		repeat (3) @(negedge SYS_CLK);
		assert (stall === 1'b0) else report_fail("rerun", 0, 32'(stall));

		if (err_cnt == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: mpu_periph.f
+incdir+include
hw/mpu_pkg.sv
hw/cpu_bus_if.sv
hw/periph_bus.sv
hw/port_regs.sv
hw/free_counter.sv
hw/sci_regs.sv
hw/irq_ctrl.sv
hw/step_ctrl.sv
hw/mpu_periph_top.sv
bench/tb_mpu_periph.sv

// File: run_sim.sh
#!/bin/sh
# build and run the peripheral block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f mpu_periph.f --top-module tb_mpu_periph \
	-o sim_tb_mpu_periph
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb_mpu_periph > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
